// File: Bender.yml
package:
  name: ps2_kbd

sources:
  - ps2_pkg.sv
  - ps2_line_if.sv
  - ps2_line_cond.sv
  - ps2_rx.sv
  - ps2_tx.sv
  - ps2_regs.sv
  - ps2_kbd.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ps2_kbd.sv

// File: files.f
+incdir+.
ps2_pkg.sv
ps2_line_if.sv
ps2_line_cond.sv
ps2_rx.sv
ps2_tx.sv
ps2_regs.sv
ps2_kbd.sv
tb_ps2_kbd.sv

// File: ps2_kbd.sv
`timescale 1ns/10ps

module ps2_kbd import ps2_pkg::*; #(
	parameter int unsigned CLK_FREQ_HZ = 50_000_000
) (
	input  logic      clk_i,
	input  logic      rst_i,
	// host register port
	input  logic      req_i,
	input  logic      we_i,
	input  logic      addr_i,
	input  ps2_byte_t wdata_i,
	output logic      ack_o,
	output ps2_byte_t rdata_o,
	output logic      irq_o,
	// keyboard lines, enables pull low
	input  logic      kclk_i,
	input  logic      kdat_i,
	output logic      kclk_en_o,
	output logic      kdat_en_o
);

	logic rx_clear;
	logic rx_full;
	ps2_byte_t rx_data;
	logic rx_par_err;
	logic tx_load;
	ps2_byte_t tx_data;
	logic tx_abort;
	logic tx_done;
	logic tx_no_ack;

	ps2_line_if line_if ();

	// line conditioning stage
	ps2_line_cond i_ps2_line_cond (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.kclk_i (kclk_i),
		.kdat_i (kdat_i),
		.line   (line_if)
	);

	// receive is enabled only while no transmit runs
	ps2_rx #(.CLK_FREQ_HZ(CLK_FREQ_HZ)) i_ps2_rx (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.line         (line_if),
		.rx_enable_i  (tx_done),
		.rx_clear_i   (rx_clear),
		.rx_full_o    (rx_full),
		.rx_data_o    (rx_data),
		.rx_par_err_o (rx_par_err)
	);

	ps2_tx #(.CLK_FREQ_HZ(CLK_FREQ_HZ)) i_ps2_tx (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.line        (line_if),
		.tx_load_i   (tx_load),
		.tx_data_i   (tx_data),
		.tx_abort_i  (tx_abort),
		.rx_full_i   (rx_full),
		.tx_done_o   (tx_done),
		.tx_no_ack_o (tx_no_ack),
		.kclk_en_o   (kclk_en_o),
		.kdat_en_o   (kdat_en_o)
	);

	ps2_regs i_ps2_regs (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.req_i        (req_i),
		.we_i         (we_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.ack_o        (ack_o),
		.rdata_o      (rdata_o),
		.rx_full_i    (rx_full),
		.rx_data_i    (rx_data),
		.rx_par_err_i (rx_par_err),
		.tx_done_i    (tx_done),
		.tx_no_ack_i  (tx_no_ack),
		.rx_clear_o   (rx_clear),
		.tx_load_o    (tx_load),
		.tx_data_o    (tx_data),
		.tx_abort_o   (tx_abort),
		.irq_o        (irq_o)
	);

endmodule

// File: ps2_line_cond.sv
`timescale 1ns/10ps

module ps2_line_cond import ps2_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     kclk_i,
	input  logic     kdat_i,
	ps2_line_if.cond line
);

	// width of the ones count and the majority threshold (4 of 7)
	localparam int unsigned VOTE_W = $clog2(DAT_VOTE_LEN + 1);
	localparam int unsigned VOTE_MIN = DAT_VOTE_LEN / 2 + 1;

	logic [CLK_SYNC_DEPTH-1:0] kclk_sync;
	logic [DAT_VOTE_LEN-1:0] kdat_sync;
	logic [VOTE_W-1:0] ones;

	// ====================
	// synchronisers
	// ====================

	// both lines idle high, so start the chains at all ones
	// and no edge shows up when reset is released
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			kclk_sync <= '1;
			kdat_sync <= '1;
		end else begin
			kclk_sync <= {kclk_sync[CLK_SYNC_DEPTH-2:0], kclk_i};
			kdat_sync <= {kdat_sync[DAT_VOTE_LEN-2:0], kdat_i};
		end
	end

	// count high samples in the data window
	always_comb begin
		ones = '0;
		for (int i = 0; i < DAT_VOTE_LEN; i++)
			ones = ones + VOTE_W'(kdat_sync[i]);
	end

	// clock level seen by the FSMs
	assign line.kclk_lvl = kclk_sync[CLK_SYNC_TAP];

	// ====================
	// edges and vote
	// ====================

	// edge pulses compare the tap with the value moving into it,
	// so each pulse lines up with the new level on kclk_lvl
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			line.kclk_fall <= 1'b0;
			line.kclk_rise <= 1'b0;
			line.kdat_bit <= 1'b1;
		end else begin
			line.kclk_fall <= kclk_sync[CLK_SYNC_TAP] & ~kclk_sync[CLK_SYNC_TAP-1];
			line.kclk_rise <= ~kclk_sync[CLK_SYNC_TAP] & kclk_sync[CLK_SYNC_TAP-1];
			// majority of the newest samples
			line.kdat_bit <= (ones >= VOTE_MIN);
		end
	end

endmodule

// File: ps2_line_if.sv
`timescale 1ns/10ps

// conditioned keyboard lines, fanned out to receiver and transmitter
interface ps2_line_if import ps2_pkg::*; ();

	// synchronised keyboard clock level
	logic kclk_lvl;
	// single cycle pulse on a falling clock edge
	logic kclk_fall;
	// single cycle pulse on a rising clock edge
	logic kclk_rise;
	// majority voted keyboard data
	logic kdat_bit;

	// driven by the line conditioner
	modport cond (
		output kclk_lvl,
		output kclk_fall,
		output kclk_rise,
		output kdat_bit
	);

	// read by rx and tx
	modport sink (
		input kclk_lvl,
		input kclk_fall,
		input kclk_rise,
		input kdat_bit
	);

endinterface

// File: ps2_pkg.sv
package ps2_pkg;

	// ====================
	// data widths
	// ====================

	// one byte on the host side
	typedef logic [7:0] ps2_byte_t;
	// start bit, eight data bits, parity and stop on the wire
	typedef logic [10:0] ps2_frame_t;
	// covers 100 us up to about 160 MHz
	typedef logic [13:0] ps2_timer_t;

	// clock synchroniser length and the stage the design looks at
	localparam int unsigned CLK_SYNC_DEPTH = 16;
	localparam int unsigned CLK_SYNC_TAP = 10;
	// data samples in the majority vote
	localparam int unsigned DAT_VOTE_LEN = 7;

	// ====================
	// register map
	// ====================

	localparam logic REG_DATA = 1'b0;
	localparam logic REG_STATUS = 1'b1;

	// status bit positions, the rest read zero
	localparam int unsigned STAT_RX_FULL = 7;
	localparam int unsigned STAT_TX_DONE = 6;
	localparam int unsigned STAT_NO_ACK = 5;
	localparam int unsigned STAT_PAR_ERR = 0;

	// commands written to the status register
	localparam ps2_byte_t CMD_CLEAR_RX = 8'h00;
	localparam ps2_byte_t CMD_ABORT_TX = 8'hFF;

	// receiver FSM
	typedef enum logic [1:0] {WAIT_FALL, CHECK_LOW, CAPTURE} rx_state_t;

	// transmitter FSM
	typedef enum logic [4:0] {
		IDLE, HOLD_CLK, WAIT_100US, DATA_LOW, WAIT_SETUP, RELEASE_CLK,
		WAIT_FIRST_FALL, FIRST_DELAY, WAIT_RISE, BIT_DELAY,
		STOP_DELAY, WAIT_ACK_FALL, ACK_DELAY, CAPTURE_ACK,
		WAIT_END_RISE, END_DELAY, FINISH
	} tx_state_t;

endpackage

// File: ps2_regs.sv
`timescale 1ns/10ps

module ps2_regs import ps2_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  logic      req_i,
	input  logic      we_i,
	input  logic      addr_i,
	input  ps2_byte_t wdata_i,
	output logic      ack_o,
	output ps2_byte_t rdata_o,
	input  logic      rx_full_i,
	input  ps2_byte_t rx_data_i,
	input  logic      rx_par_err_i,
	input  logic      tx_done_i,
	input  logic      tx_no_ack_i,
	output logic      rx_clear_o,
	output logic      tx_load_o,
	output ps2_byte_t tx_data_o,
	output logic      tx_abort_o,
	output logic      irq_o
);

	// new request seen, previous one fully closed
	logic access;
	ps2_byte_t status;

	assign access = req_i & ~ack_o;

	// status byte, unused bits read zero
	always_comb begin
		status = '0;
		status[STAT_RX_FULL] = rx_full_i;
		status[STAT_TX_DONE] = tx_done_i;
		status[STAT_NO_ACK] = tx_no_ack_i;
		status[STAT_PAR_ERR] = rx_par_err_i;
	end

	// ====================
	// req/ack handshake
	// ====================

	// ack rises on the access edge, falls once req is seen low
	always_ff @(posedge clk_i) begin
		if (rst_i)
			ack_o <= 1'b0;
		else if (access)
			ack_o <= 1'b1;
		else if (!req_i)
			ack_o <= 1'b0;
	end

	// command pulses, one cycle each
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rx_clear_o <= 1'b0;
			tx_load_o <= 1'b0;
			tx_abort_o <= 1'b0;
		end else begin
			tx_load_o <= access & we_i & (addr_i == REG_DATA);
			rx_clear_o <= access & we_i & (addr_i == REG_STATUS) &
				(wdata_i == CMD_CLEAR_RX);
			tx_abort_o <= access & we_i & (addr_i == REG_STATUS) &
				(wdata_i == CMD_ABORT_TX);
		end
	end

	// read data and the byte to send, both hold until the next access
	always_ff @(posedge clk_i) begin
		if (access) begin
			if (we_i) begin
				rdata_o <= '0;
				if (addr_i == REG_DATA)
					tx_data_o <= wdata_i;
			end else begin
				rdata_o <= (addr_i == REG_DATA) ? rx_data_i : status;
			end
		end
	end

	// interrupt while a received byte waits
	assign irq_o = rx_full_i;

endmodule

// File: ps2_rx.sv
`timescale 1ns/10ps

module ps2_rx import ps2_pkg::*; #(
	parameter int unsigned CLK_FREQ_HZ = 50_000_000
) (
	input  logic      clk_i,
	input  logic      rst_i,
	ps2_line_if.sink  line,
	input  logic      rx_enable_i,
	input  logic      rx_clear_i,
	output logic      rx_full_o,
	output ps2_byte_t rx_data_o,
	output logic      rx_par_err_o
);

	// clocks in 5 us
	localparam ps2_timer_t T5US = ps2_timer_t'(CLK_FREQ_HZ / 200_000);

	rx_state_t state;
	ps2_timer_t timer;
	// shifts in from the top, start bit ends up in bit 0
	ps2_frame_t frame;

	// ====================
	// receive FSM
	// ====================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= WAIT_FALL;
			timer <= '0;
			frame <= '1;
		end else begin
			// host read the byte, back to empty
			if (rx_clear_i)
				frame <= '1;

			case (state)
				// falling edge starts the debounce timer
				WAIT_FALL: begin
					timer <= '0;
					if (line.kclk_fall && rx_enable_i)
						state <= CHECK_LOW;
				end

				// clock must still be low after 5 us
				CHECK_LOW: begin
					if (!rx_enable_i) begin
						// a transmit took over the lines
						state <= WAIT_FALL;
					end else if (timer == T5US) begin
						if (line.kclk_lvl)
							// glitch, not a real clock
							state <= WAIT_FALL;
						else
							state <= CAPTURE;
					end else begin
						timer <= timer + 1'b1;
					end
				end

				// keyboard sends lsb first
				CAPTURE: begin
					frame <= {line.kdat_bit, frame[10:1]};
					state <= WAIT_FALL;
				end

				default: state <= WAIT_FALL;
			endcase
		end
	end

	// zero start bit has reached bit 0
	assign rx_full_o = ~frame[0];
	assign rx_data_o = frame[8:1];
	// odd parity over data and parity bit
	assign rx_par_err_o = ~^frame[9:1];

endmodule

// File: ps2_tx.sv
`timescale 1ns/10ps

module ps2_tx import ps2_pkg::*; #(
	parameter int unsigned CLK_FREQ_HZ = 50_000_000
) (
	input  logic      clk_i,
	input  logic      rst_i,
	ps2_line_if.sink  line,
	input  logic      tx_load_i,
	input  ps2_byte_t tx_data_i,
	input  logic      tx_abort_i,
	input  logic      rx_full_i,
	output logic      tx_done_o,
	output logic      tx_no_ack_o,
	output logic      kclk_en_o,
	output logic      kdat_en_o
);

	// clocks in 5 us and in 100 us
	localparam ps2_timer_t T5US = ps2_timer_t'(CLK_FREQ_HZ / 200_000);
	localparam ps2_timer_t T100US = ps2_timer_t'(CLK_FREQ_HZ / 10_000);

	tx_state_t state;
	ps2_timer_t timer;
	ps2_frame_t frame;
	// bits still to leave the line
	logic [3:0] bit_cnt;
	// host pulls the clock low
	logic clk_hold;
	// frame bit 0 drives the data line
	logic shift_en;
	logic done;
	logic ack_bit;
	logic shift;

	// one bit moves out on every rising clock while sending
	assign shift = (state == WAIT_RISE) && line.kclk_rise;

	// ====================
	// transmit FSM
	// ====================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= IDLE;
			timer <= '0;
			bit_cnt <= '0;
			clk_hold <= 1'b0;
			shift_en <= 1'b0;
			done <= 1'b1;
			ack_bit <= 1'b1;
		end else if (tx_load_i) begin
			// a data write starts a new transfer from any state
			state <= HOLD_CLK;
			timer <= '0;
			bit_cnt <= 4'd11;
			shift_en <= 1'b0;
			done <= 1'b0;
		end else if (tx_abort_i) begin
			state <= IDLE;
			clk_hold <= 1'b0;
			shift_en <= 1'b0;
			done <= 1'b1;
		end else begin
			// free running, cleared on entry to each wait
			timer <= timer + 1'b1;
			case (state)
				IDLE: timer <= '0;
				// request to send, clock low first
				HOLD_CLK: begin
					clk_hold <= 1'b1;
					timer <= '0;
					state <= WAIT_100US;
				end
				WAIT_100US: if (timer == T100US) state <= DATA_LOW;
				// start bit goes on the line
				DATA_LOW: begin
					shift_en <= 1'b1;
					timer <= '0;
					state <= WAIT_SETUP;
				end
				WAIT_SETUP: if (timer == T5US) state <= RELEASE_CLK;
				// keyboard now drives the clock
				RELEASE_CLK: begin
					clk_hold <= 1'b0;
					state <= WAIT_FIRST_FALL;
				end
				WAIT_FIRST_FALL: begin
					timer <= '0;
					if (line.kclk_fall) state <= FIRST_DELAY;
				end
				FIRST_DELAY: if (timer == T5US) state <= WAIT_RISE;
				// data, parity, stop, then the rise after the stop clock
				WAIT_RISE: begin
					timer <= '0;
					if (line.kclk_rise) begin
						bit_cnt <= bit_cnt - 4'd1;
						if (bit_cnt == 4'd1) begin
							shift_en <= 1'b0;
							state <= STOP_DELAY;
						end else begin
							state <= BIT_DELAY;
						end
					end
				end
				BIT_DELAY: if (timer == T5US) state <= WAIT_RISE;
				STOP_DELAY: if (timer == T5US) state <= WAIT_ACK_FALL;
				// keyboard answers on the next falling clock
				WAIT_ACK_FALL: begin
					timer <= '0;
					if (line.kclk_fall) state <= ACK_DELAY;
				end
				ACK_DELAY: if (timer == T5US) state <= CAPTURE_ACK;
				// low means the keyboard took the byte
				CAPTURE_ACK: begin
					ack_bit <= line.kdat_bit;
					state <= WAIT_END_RISE;
				end
				WAIT_END_RISE: begin
					timer <= '0;
					if (line.kclk_rise) state <= END_DELAY;
				end
				END_DELAY: if (timer == T5US) state <= FINISH;
				FINISH: begin
					done <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// start 0, data lsb first, odd parity, stop 1, and ones fill behind
	always_ff @(posedge clk_i) begin
		if (tx_load_i)
			frame <= {1'b1, ~^tx_data_i, tx_data_i, 1'b0};
		else if (shift)
			frame <= {1'b1, frame[10:1]};
	end

	assign tx_done_o = done;
	assign tx_no_ack_o = ack_bit;
	// an unread byte also holds the clock to stop the keyboard sending
	assign kclk_en_o = clk_hold | rx_full_i;
	assign kdat_en_o = shift_en & ~frame[0];

endmodule

// File: tb_kbd_model.svh
`ifndef TB_KBD_MODEL_SVH
`define TB_KBD_MODEL_SVH

// ====================
// keyboard to host
// ====================

// one frame from the keyboard, data changes while the clock is high
task automatic send_frame(input ps2_byte_t data, input logic par_ok);
	ps2_frame_t bits;
	// start low, data lsb first, parity, stop high
	bits = {1'b1, odd_parity(data) ^ ~par_ok, data, 1'b0};
	for (int i = 0; i < 11; i++) begin
		kb_dat_pull = ~bits[i];
		wait_cycles(HALF_CYCLES);
		// a keyboard stops sending while the host inhibits the clock
		if (!kclk_i) begin
			line_errors++;
			$display("keyboard clock held low by the host before bit %0d", i);
		end
		kb_clk_pull = 1'b1;
		wait_cycles(HALF_CYCLES);
		kb_clk_pull = 1'b0;
	end
	// leave the data line idle high
	kb_dat_pull = 1'b0;
endtask

// ====================
// host to keyboard
// ====================

// waits for request to send, clocks the frame in and answers with an ack
task automatic receive_host_frame(input logic give_ack, output ps2_frame_t bits);
	int n;
	n = 0;
	// host pulls the clock low first
	while (kclk_i && n < 1000) begin
		tick();
		n++;
	end
	if (kclk_i)
		timeout_abort("host never pulled the keyboard clock low");
	n = 0;
	while (!kclk_i && n < 1000) begin
		tick();
		n++;
	end
	if (!kclk_i)
		timeout_abort("host never released the keyboard clock");
	// sample each bit at the end of the high phase, the host shifts after a rise
	for (int i = 0; i < 11; i++) begin
		wait_cycles(HALF_CYCLES);
		bits[i] = kdat_i;
		kb_clk_pull = 1'b1;
		wait_cycles(HALF_CYCLES);
		kb_clk_pull = 1'b0;
	end
	// ack bit on one more clock
	wait_cycles(HALF_CYCLES / 2);
	kb_dat_pull = give_ack;
	wait_cycles(HALF_CYCLES / 2);
	kb_clk_pull = 1'b1;
	wait_cycles(HALF_CYCLES);
	kb_clk_pull = 1'b0;
	kb_dat_pull = 1'b0;
endtask

`endif

// File: tb_ps2_kbd.sv
`timescale 1ns/10ps

module tb_ps2_kbd import ps2_pkg::*; ();

	// 2 MHz gives 10 cycles for 5 us and 200 for 100 us
	localparam int unsigned CLK_FREQ_HZ = 2_000_000;
	// 40 us keyboard half period
	localparam int HALF_CYCLES = 80;
	localparam int BUS_TIMEOUT = 20;

	logic clk_i = 1'b0;
	logic rst_i;
	logic req_i;
	logic we_i;
	logic addr_i;
	ps2_byte_t wdata_i;
	logic ack_o;
	ps2_byte_t rdata_o;
	logic irq_o;
	logic kclk_i;
	logic kdat_i;
	logic kclk_en_o;
	logic kdat_en_o;

	// keyboard side pulls work open collector like the DUT enables
	logic kb_clk_pull = 1'b0;
	logic kb_dat_pull = 1'b0;

	int errors = 0;
	int line_errors = 0;
	int timeouts = 0;
	logic [31:0] rng_state = 32'h2bb6_5263;

	always #5 clk_i = ~clk_i;

	// pull-ups keep both lines high unless either side pulls low
	assign kclk_i = ~((kclk_en_o === 1'b1) | kb_clk_pull);
	assign kdat_i = ~((kdat_en_o === 1'b1) | kb_dat_pull);

	ps2_kbd #(.CLK_FREQ_HZ(CLK_FREQ_HZ)) i_ps2_kbd (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.req_i     (req_i),
		.we_i      (we_i),
		.addr_i    (addr_i),
		.wdata_i   (wdata_i),
		.ack_o     (ack_o),
		.rdata_o   (rdata_o),
		.irq_o     (irq_o),
		.kclk_i    (kclk_i),
		.kdat_i    (kdat_i),
		.kclk_en_o (kclk_en_o),
		.kdat_en_o (kdat_en_o)
	);

	// ====================
	// helpers
	// ====================

	// step to 1 ns after the next rising edge
	task automatic tick();
		@(posedge clk_i);
		#1;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) tick();
	endtask

	task automatic report_and_finish();
		$display("%0d value errors, %0d line errors, %0d timeouts",
			errors, line_errors, timeouts);
		if (errors == 0 && line_errors == 0 && timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	task automatic timeout_abort(input string what);
		timeouts++;
		$display("timeout at %0t: %s", $time, what);
		report_and_finish();
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic ps2_byte_t next_byte();
		rng_state = xorshift(rng_state);
		return rng_state[7:0];
	endfunction

	// parity bit that makes the count of ones odd
	function automatic logic odd_parity(input ps2_byte_t data);
		int ones;
		ones = 0;
		for (int i = 0; i < 8; i++)
			ones += data[i];
		return (ones % 2 == 0);
	endfunction

	// expected status byte from the register map
	function automatic ps2_byte_t status_byte(input logic full, input logic done,
		input logic no_ack, input logic par_err);
		ps2_byte_t s;
		s = '0;
		s[STAT_RX_FULL] = full;
		s[STAT_TX_DONE] = done;
		s[STAT_NO_ACK] = no_ack;
		s[STAT_PAR_ERR] = par_err;
		return s;
	endfunction

	task automatic check_byte(input string what, input ps2_byte_t got, input ps2_byte_t exp);
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	`include "tb_kbd_model.svh"

	// ====================
	// host port
	// ====================

	// one four-phase access with read data taken while ack is high
	task automatic bus_access(input logic we, input logic addr, input ps2_byte_t wdata,
		output ps2_byte_t rdata);
		int n;
		req_i = 1'b1;
		we_i = we;
		addr_i = addr;
		wdata_i = wdata;
		n = 0;
		tick();
		while (!ack_o && n < BUS_TIMEOUT) begin
			tick();
			n++;
		end
		if (!ack_o)
			timeout_abort("no ack from the register port");
		rdata = rdata_o;
		req_i = 1'b0;
		we_i = 1'b0;
		n = 0;
		tick();
		while (ack_o && n < BUS_TIMEOUT) begin
			tick();
			n++;
		end
		if (ack_o)
			timeout_abort("ack stayed high after req dropped");
	endtask

	task automatic bus_write(input logic addr, input ps2_byte_t data);
		ps2_byte_t unused;
		bus_access(1'b1, addr, data, unused);
	endtask

	task automatic bus_read(input logic addr, output ps2_byte_t data);
		bus_access(1'b0, addr, 8'h00, data);
	endtask

	task automatic wait_irq(input logic level, input string what);
		int n;
		n = 0;
		while (irq_o !== level && n < 300) begin
			tick();
			n++;
		end
		if (irq_o !== level)
			timeout_abort(what);
	endtask

	// poll status until the transmitter reports done
	task automatic wait_tx_done(output ps2_byte_t st);
		int n;
		n = 0;
		bus_read(REG_STATUS, st);
		while (!st[STAT_TX_DONE] && n < 100) begin
			bus_read(REG_STATUS, st);
			n++;
		end
		if (!st[STAT_TX_DONE])
			timeout_abort("transmitter never reported done");
	endtask

	task automatic clear_rx();
		bus_write(REG_STATUS, CMD_CLEAR_RX);
		wait_irq(1'b0, "irq did not drop after clear");
	endtask

	// ====================
	// directed tests
	// ====================

	task automatic test_reset_state();
		ps2_byte_t rd;
		bus_read(REG_STATUS, rd);
		check_byte("status after reset", rd, status_byte(0, 1, 1, 0));
		check_bit("irq after reset", irq_o, 1'b0);
		check_bit("clock enable after reset", kclk_en_o, 1'b0);
		check_bit("data enable after reset", kdat_en_o, 1'b0);
	endtask

	task automatic test_receive();
		ps2_byte_t b;
		ps2_byte_t rd;
		repeat (4) begin
			b = next_byte();
			send_frame(b, 1'b1);
			wait_irq(1'b1, "irq did not rise after a frame");
			// unread byte inhibits the keyboard
			check_bit("clock hold while full", kclk_en_o, 1'b1);
			bus_read(REG_DATA, rd);
			check_byte("received byte", rd, b);
			bus_read(REG_STATUS, rd);
			check_byte("status after receive", rd, status_byte(1, 1, 1, 0));
			clear_rx();
		end
	endtask

	task automatic test_parity_error();
		ps2_byte_t b;
		ps2_byte_t rd;
		b = next_byte();
		send_frame(b, 1'b0);
		wait_irq(1'b1, "irq did not rise after a bad parity frame");
		bus_read(REG_DATA, rd);
		check_byte("byte with bad parity", rd, b);
		bus_read(REG_STATUS, rd);
		check_byte("status after bad parity", rd, status_byte(1, 1, 1, 1));
	endtask

	// byte from the parity test is still held here
	task automatic test_clear_rx();
		ps2_byte_t b;
		ps2_byte_t rd;
		clear_rx();
		check_bit("clock hold after clear", kclk_en_o, 1'b0);
		bus_read(REG_STATUS, rd);
		check_byte("status after clear", rd, status_byte(0, 1, 1, 0));
		b = next_byte();
		send_frame(b, 1'b1);
		wait_irq(1'b1, "irq did not rise on the byte after clear");
		bus_read(REG_DATA, rd);
		check_byte("byte after clear", rd, b);
		clear_rx();
	endtask

	task automatic test_transmit(input logic give_ack);
		ps2_byte_t b;
		ps2_byte_t rd;
		ps2_frame_t bits;
		b = next_byte();
		bus_write(REG_DATA, b);
		receive_host_frame(give_ack, bits);
		check_bit("tx start bit", bits[0], 1'b0);
		check_byte("tx data", bits[8:1], b);
		check_bit("tx parity", bits[9], odd_parity(b));
		check_bit("tx stop bit", bits[10], 1'b1);
		wait_tx_done(rd);
		check_byte("status after transmit", rd, status_byte(0, 1, ~give_ack, 0));
	endtask

	// the missing ack of the previous transfer stays visible after the abort
	task automatic test_abort();
		ps2_byte_t rd;
		int n;
		bus_write(REG_DATA, next_byte());
		n = 0;
		while (kclk_i && n < 50) begin
			tick();
			n++;
		end
		if (kclk_i)
			timeout_abort("host never started the clock hold");
		// well inside the 200 cycle hold
		wait_cycles(50);
		bus_write(REG_STATUS, CMD_ABORT_TX);
		wait_tx_done(rd);
		check_byte("status after abort", rd, status_byte(0, 1, 1, 0));
		check_bit("clock enable after abort", kclk_en_o, 1'b0);
		check_bit("data enable after abort", kdat_en_o, 1'b0);
	endtask

	initial begin
		rst_i = 1'b1;
		req_i = 1'b0;
		we_i = 1'b0;
		addr_i = 1'b0;
		wdata_i = '0;
		wait_cycles(5);
		rst_i = 1'b0;
		tick();
		test_reset_state();
		test_receive();
		test_parity_error();
		test_clear_rx();
		test_transmit(1'b1);
		test_transmit(1'b0);
		test_abort();
		report_and_finish();
	end

endmodule
